//--- tb.f
+incdir+tests
common/bldc_pkg.sv
phase_pwm/phase_pwm.sv
hall_monitor/hall_monitor.sv
motor_fsm/motor_fsm.sv
verilog/hall_commutator.sv
verilog/bldc_driver.sv
tests/tb_bldc_driver.sv

//--- run_sim.sh
#!/bin/sh
# Builds the BLDC testbench with Verilator, runs it and checks the log for the pass message
verilator --binary --timing --assert --top-module tb_bldc_driver -f tb.f -o sim_bldc \
    > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/sim_bldc > sim.log 2>&1 || echo "Simulation exited with an error status"
cat sim.log
grep -q "Test completed successfully" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

//--- tests/tb_bldc_checks.svh
/* Reference model, compare tasks and period measurement for the BLDC testbench.
   Included inside the testbench module; uses its parameters and DUT signals. */

`ifndef TB_BLDC_CHECKS_SVH
`define TB_BLDC_CHECKS_SVH

// Cycles per PWM period that each phase output was on, phase A in element 0
typedef logic [NUM_PHASES-1:0][7:0] count_vec_t;

// Prints the reason, then ends the run as failed
task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Test failed");
    $fatal(1);
endtask

// Six-step table from the spec, one-hot per phase with A in bit 0
function automatic void ref_drive(input hall_code_t code, input logic dir, input int duty,
                                  output phase_sel_t hi, output phase_sel_t lo,
                                  output int on_time);
    int top;
    case (code)
        3'b001: {hi, lo} = {3'b001, 3'b010};
        3'b011: {hi, lo} = {3'b001, 3'b100};
        3'b010: {hi, lo} = {3'b010, 3'b100};
        3'b110: {hi, lo} = {3'b010, 3'b001};
        3'b100: {hi, lo} = {3'b100, 3'b001};
        3'b101: {hi, lo} = {3'b100, 3'b010};
        default: {hi, lo} = 6'b0;
    endcase
    // Reverse rotation swaps the switched pair
    if (!dir) begin
        {hi, lo} = {lo, hi};
    end
    // High side conducts from DEAD_TIME up to the duty, capped at the carrier top
    top = (duty > PWM_MAX + 1) ? PWM_MAX + 1 : duty;
    on_time = (hi != '0 && top > DEAD_TIME) ? top - DEAD_TIME : 0;
endfunction

function automatic phase_sel_t active_phases(input count_vec_t cnt);
    phase_sel_t v;
    for (int p = 0; p < NUM_PHASES; p++) begin
        v[p] = (cnt[p] != 8'd0);
    end
    return v;
endfunction

// Any PERIOD consecutive samples cover each carrier count exactly once
task automatic measure_period(output count_vec_t h_cnt, output count_vec_t l_cnt);
    h_cnt = '0;
    l_cnt = '0;
    repeat (PERIOD) begin
        @(negedge clk);
        for (int p = 0; p < NUM_PHASES; p++) begin
            h_cnt[p] = h_cnt[p] + 8'(phase_h[p]);
            l_cnt[p] = l_cnt[p] + 8'(phase_l[p]);
        end
    end
endtask

task automatic check_gates(input string what, input phase_sel_t exp, input phase_sel_t act);
    if (exp !== act) begin
        abort_run($sformatf("Error: %s, %s: expected %b, actual %b",
                            test_name, what, exp, act));
    end
endtask

task automatic check_count(input string what, input int exp, input int act);
    if (exp != act) begin
        abort_run($sformatf("Error: %s, %s: expected %0d, actual %0d",
                            test_name, what, exp, act));
    end
endtask

task automatic check_flag(input string what, input logic exp, input logic act);
    if (exp !== act) begin
        abort_run($sformatf("Error: %s, %s: expected %b, actual %b",
                            test_name, what, exp, act));
    end
endtask

// Polls the FSM state on falling edges, bounded by max_cycles
task automatic wait_state(input motor_state_t want, input int max_cycles);
    int n;
    n = 0;
    while (DUT.state != want && n < max_cycles) begin
        @(negedge clk);
        n++;
    end
    if (DUT.state != want) begin
        abort_run($sformatf("State %s was not reached within %0d cycles in %s",
                            want.name(), max_cycles, test_name));
    end
endtask

`endif

//--- tests/tb_bldc_driver.sv
/* Testbench for the BLDC controller. Parameters are shrunk so a PWM period is 32
   clocks and a hall fault is seen after three samples four cycles apart. */

`timescale 1ns/1ps
`default_nettype none

module tb_bldc_driver import bldc_pkg::*; ();

    localparam int CLK_PERIOD        = 10;
    localparam int PWM_MAX           = 31;
    localparam int DUTY_WIDTH        = 6;
    localparam int DEAD_TIME         = 2;
    localparam int MIN_DUTY          = 6;
    localparam int RAMP_PERIOD       = 64;
    localparam int RAMP_STEPS        = 4;
    localparam int HALL_SAMPLE_DIV   = 4;
    localparam int HALL_STEADY_COUNT = 3;
    localparam int PERIOD            = PWM_MAX + 1;
    localparam int RAMP_CYCLES       = (RAMP_STEPS + 1) * RAMP_PERIOD;
    localparam int RAMP_WINDOWS      = RAMP_CYCLES / PERIOD + 3;
    localparam int FAULT_CYCLES      = 2 * HALL_SAMPLE_DIV * (HALL_STEADY_COUNT + 2);
    // Covers reset, four ramps, twelve commutation steps and the stop and fault phases
    localparam int TEST_CYCLES = 16 + 4 * RAMP_CYCLES + 12 * 5 * PERIOD + 30 * PERIOD
                                 + 4 * FAULT_CYCLES;
    localparam int WATCHDOG_CYCLES = 2 * TEST_CYCLES;

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic                  en;
    hall_code_t            hall;
    logic [DUTY_WIDTH-1:0] duty_cycle;
    logic                  direction;
    phase_sel_t            phase_h, phase_l;
    logic                  connected, fault;

    string test_name       = "reset";
    logic  steady_chk      = 1'b0;
    int    chk_epoch       = 0;
    int    periods_checked = 0;
    int    seed            = 28;
    int    run_duty;

`include "tb_bldc_checks.svh"

    bldc_driver #(.PWM_MAX(PWM_MAX), .DUTY_WIDTH(DUTY_WIDTH), .DEAD_TIME(DEAD_TIME),
        .MIN_DUTY(MIN_DUTY), .RAMP_PERIOD(RAMP_PERIOD), .RAMP_STEPS(RAMP_STEPS),
        .HALL_SAMPLE_DIV(HALL_SAMPLE_DIV), .HALL_STEADY_COUNT(HALL_STEADY_COUNT)) DUT (
        .clk, .rst_n, .en, .hall, .duty_cycle, .direction,
        .phase_h, .phase_l, .connected, .fault
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ======================================================================
    // Checkers
    // ======================================================================
    always @(negedge clk) begin
        check_gates("shoot-through", '0, phase_h & phase_l);
    end

    // Compares each full PWM period taken while the stimulus holds its inputs
    always begin : period_monitor
        int epoch;
        int on_t;
        count_vec_t hc, lc;
        phase_sel_t hi, lo;
        @(negedge clk);
        if (steady_chk) begin
            epoch = chk_epoch;
            measure_period(hc, lc);
            // A window that saw the inputs change is thrown away
            if (steady_chk && epoch == chk_epoch) begin
                ref_drive(hall, direction, int'(duty_cycle), hi, lo, on_t);
                check_gates("high-side phases", hi, active_phases(hc));
                check_gates("switched phases", hi | lo, active_phases(hc) | active_phases(lc));
                for (int p = 0; p < NUM_PHASES; p++) begin
                    if (hi[p]) begin
                        check_count("high-side on-time", on_t, int'(hc[p]));
                    end
                    if (lo[p]) begin
                        check_count("low-side on-time", PERIOD - DEAD_TIME, int'(lc[p]));
                    end
                end
                periods_checked++;
            end
        end
    end

    // ======================================================================
    // Stimulus
    // ======================================================================
    initial begin : stimulus
        int         rnd;
        int         on_now;
        int         on_prev;
        count_vec_t hc, lc;
        hall_code_t codes [6];
        codes = '{3'b001, 3'b011, 3'b010, 3'b110, 3'b100, 3'b101};
        rst_n      <= 1'b0;
        en         <= 1'b0;
        hall       <= 3'b001;
        duty_cycle <= '0;
        direction  <= 1'b1;
        repeat (8) @(negedge clk);
        rst_n <= 1'b1;
        @(negedge clk);

        // The ramp starts at MIN_DUTY and is measured on phase A because code 001 drives A high
        test_name = "ramp";
        rnd = $random(seed);
        run_duty = MIN_DUTY + RAMP_STEPS + 1 + int'($unsigned(rnd) % 16);
        duty_cycle <= DUTY_WIDTH'(run_duty);
        en         <= 1'b1;
        wait_state(ST_STARTUP, 4);
        for (int i = 0; i < RAMP_WINDOWS; i++) begin
            measure_period(hc, lc);
            on_now = int'(hc[0]);
            if (i == 0) begin
                check_count("first on-time", MIN_DUTY - DEAD_TIME, on_now);
            end else if (on_now < on_prev) begin
                abort_run($sformatf("Error: %s, on-time: expected at least %0d, actual %0d",
                                    test_name, on_prev, on_now));
            end
            on_prev = on_now;
        end
        check_count("settled on-time", run_duty - DEAD_TIME, on_prev);
        wait_state(ST_RUN, 4);

        // Walk all six codes in both directions with two settling periods per step
        test_name = "commutation";
        for (int d = 1; d >= 0; d--) begin
            for (int k = 0; k < 6; k++) begin
                @(negedge clk);
                steady_chk <= 1'b0;
                hall       <= codes[k];
                direction  <= d[0];
                repeat (2 * PERIOD) @(negedge clk);
                chk_epoch  <= chk_epoch + 1;
                steady_chk <= 1'b1;
                repeat (3 * PERIOD) @(negedge clk);
            end
        end
        @(negedge clk);
        steady_chk <= 1'b0;
        hall       <= 3'b001;
        direction  <= 1'b1;

        test_name = "stop";
        duty_cycle <= DUTY_WIDTH'(MIN_DUTY);
        wait_state(ST_STOP, 4);
        repeat (2) @(negedge clk);
        measure_period(hc, lc);
        check_gates("gates after stop", '0, active_phases(hc) | active_phases(lc));

        // Pulled-up sensor lines read 111
        test_name = "disconnect";
        duty_cycle <= DUTY_WIDTH'(run_duty);
        wait_state(ST_RUN, RAMP_CYCLES + 8);
        hall <= HALL_ALL_HIGH;
        wait_state(ST_POLL_HALL, FAULT_CYCLES);
        check_flag("connected", 1'b0, connected);
        repeat (2) @(negedge clk);
        measure_period(hc, lc);
        check_gates("gates while disconnected", '0, active_phases(hc) | active_phases(lc));
        check_flag("fault", 1'b0, fault);
        hall <= 3'b001;
        wait_state(ST_STARTUP, FAULT_CYCLES);
        check_flag("connected after reconnect", 1'b1, connected);

        test_name = "hardware fault";
        wait_state(ST_RUN, RAMP_CYCLES + 8);
        hall <= HALL_ALL_LOW;
        wait_state(ST_ERROR, FAULT_CYCLES);
        @(negedge clk);
        check_flag("fault", 1'b1, fault);
        measure_period(hc, lc);
        check_gates("gates on fault", '0, active_phases(hc) | active_phases(lc));
        en <= 1'b0;
        wait_state(ST_STOP, 4);
        check_flag("fault with en low", 1'b0, fault);
        en <= 1'b1;
        wait_state(ST_ERROR, 4);
        @(negedge clk);
        check_flag("fault after re-enable", 1'b1, fault);

        // Only rst_n clears the latched hardware fault
        hall  <= 3'b001;
        rst_n <= 1'b0;
        repeat (2) @(negedge clk);
        rst_n <= 1'b1;
        check_flag("fault after reset", 1'b0, fault);
        test_name = "commutation after reset";
        wait_state(ST_RUN, RAMP_CYCLES + 8);
        repeat (PERIOD) @(negedge clk);
        chk_epoch  <= chk_epoch + 1;
        steady_chk <= 1'b1;
        repeat (3 * PERIOD) @(negedge clk);
        steady_chk <= 1'b0;
        @(negedge clk);

        if (periods_checked < 12) begin
            abort_run($sformatf("Only %0d PWM periods were compared", periods_checked));
        end else begin
            $display("Test completed successfully");
            $finish;
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        abort_run($sformatf("Timeout after %0d cycles in %s", WATCHDOG_CYCLES, test_name));
    end

endmodule

`default_nettype wire

//--- verilog/bldc_driver.sv
/* BLDC motor controller top. hall is asynchronous and goes through a
   two-flop synchronizer; all other inputs are assumed to be in the clk domain. */

`timescale 1ns/1ps
`default_nettype none

module bldc_driver import bldc_pkg::*; #(
    parameter int PWM_MAX           = 1023,
    parameter int DUTY_WIDTH        = 10,
    parameter int DEAD_TIME         = 3,
    parameter int MIN_DUTY          = 20,
    parameter int RAMP_PERIOD       = 8192,
    parameter int RAMP_STEPS        = 255,
    parameter int HALL_SAMPLE_DIV   = 64,
    parameter int HALL_STEADY_COUNT = 31
) (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  en,
    input  wire hall_code_t            hall,
    input  wire logic [DUTY_WIDTH-1:0] duty_cycle,
    input  wire logic                  direction,
    output phase_sel_t                 phase_h,
    output phase_sel_t                 phase_l,
    output logic                       connected,
    output logic                       fault
);

    hall_code_t hall_meta, hall_s;
    logic hw_fault, disconnected, fault_event, drive_en;
    motor_state_t state;
    logic [DUTY_WIDTH-1:0] drive_duty;
    phase_sel_t drive_sel, float_sel;

    // Two-flop synchronizer for the raw hall lines
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hall_meta <= '0;
            hall_s    <= '0;
        end else begin
            hall_meta <= hall;
            hall_s    <= hall_meta;
        end
    end

    hall_monitor #(.HALL_SAMPLE_DIV(HALL_SAMPLE_DIV), .HALL_STEADY_COUNT(HALL_STEADY_COUNT))
        u_hall_monitor (.clk, .rst_n, .hall_s, .state, .hw_fault, .disconnected, .fault_event);

    motor_fsm #(.DUTY_WIDTH(DUTY_WIDTH), .MIN_DUTY(MIN_DUTY), .RAMP_PERIOD(RAMP_PERIOD),
        .RAMP_STEPS(RAMP_STEPS)) u_motor_fsm (.clk, .rst_n, .en, .duty_cycle, .fault_event,
        .hw_fault, .disconnected, .state, .drive_duty, .drive_en, .fault);

    hall_commutator u_commutator (.hall_s, .direction, .drive_sel, .float_sel);

    // Only the high phase gets the duty; the low phase runs at zero duty, so its
    // low-side gate stays on apart from the dead-time window
    for (genvar j = 0; j < NUM_PHASES; j++) begin : g_phase
        phase_pwm #(.PWM_MAX(PWM_MAX), .DUTY_WIDTH(DUTY_WIDTH), .DEAD_TIME(DEAD_TIME)) u_pwm (
            .clk,
            .rst_n,
            .duty        (drive_sel[j] ? drive_duty : '0),
            .float_phase (float_sel[j] | ~drive_en),
            .gate_h      (phase_h[j]),
            .gate_l      (phase_l[j])
        );
    end

    assign connected = ~disconnected;

endmodule

`default_nettype wire

//--- verilog/hall_commutator.sv
/* Six-step commutation decode. Purely combinational; hall_s must already be
   synchronized. Invalid codes float all three phases. */

`timescale 1ns/1ps
`default_nettype none

module hall_commutator import bldc_pkg::*; (
    input  wire hall_code_t hall_s,
    input  wire logic       direction,
    output phase_sel_t      drive_sel,
    output phase_sel_t      float_sel
);

    commutation_t comm;

    always_comb begin
        comm = commutate(hall_s, direction);

        // Default is everything floating with nothing driven
        drive_sel = '0;
        float_sel = '1;

        if (comm.valid) begin
            // The high phase is the only one that receives PWM duty
            drive_sel[comm.high] = 1'b1;

            // High and low phases are both switched, the remaining one floats
            float_sel[comm.high] = 1'b0;
            float_sel[comm.low]  = 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- motor_fsm/motor_fsm.sv
/* Motor state machine with fixed-time startup ramp. en low forces stop and
   clears fault, but a latched hardware fault sends it back to error. */

`timescale 1ns/1ps
`default_nettype none

module motor_fsm import bldc_pkg::*; #(
    parameter int DUTY_WIDTH  = 10,
    parameter int MIN_DUTY    = 20,
    parameter int RAMP_PERIOD = 8192,
    parameter int RAMP_STEPS  = 255
) (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  en,
    input  wire logic [DUTY_WIDTH-1:0] duty_cycle,
    input  wire logic                  fault_event,
    input  wire logic                  hw_fault,
    input  wire logic                  disconnected,
    output motor_state_t               state,
    output logic [DUTY_WIDTH-1:0]      drive_duty,
    output logic                       drive_en,
    output logic                       fault
);

    localparam int RAMP_W = (RAMP_PERIOD > 1) ? $clog2(RAMP_PERIOD) : 1;
    localparam int STEP_W = $clog2(RAMP_STEPS + 1);
    localparam logic [DUTY_WIDTH-1:0] MIN_D = DUTY_WIDTH'(MIN_DUTY);

    logic [RAMP_W-1:0] ramp_cnt;
    logic [STEP_W-1:0] step_cnt;
    logic duty_low, ramp_tick;

    // Below or at the minimum the motor cannot be kept turning
    assign duty_low  = (duty_cycle <= MIN_D);
    assign ramp_tick = (ramp_cnt == RAMP_W'(RAMP_PERIOD - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= ST_STOP;
            drive_duty <= '0;
            drive_en   <= 1'b0;
            fault      <= 1'b0;
            ramp_cnt   <= '0;
            step_cnt   <= '0;
        end else if (!en) begin
            state      <= ST_STOP;
            drive_duty <= '0;
            drive_en   <= 1'b0;
            fault      <= 1'b0;
        end else if (fault_event) begin
            // Hardware fault wins over a disconnect seen at the same time
            state      <= (hw_fault || !disconnected) ? ST_ERROR : ST_POLL_HALL;
            drive_duty <= '0;
            drive_en   <= 1'b0;
        end else begin
            case (state)
                ST_STOP: begin
                    drive_duty <= '0;
                    drive_en   <= 1'b0;
                    ramp_cnt   <= '0;
                    step_cnt   <= '0;
                    if (hw_fault) begin
                        state <= ST_ERROR;
                    end else if (disconnected) begin
                        state <= ST_POLL_HALL;
                    end else if (!duty_low) begin
                        // Ramp begins at the minimum running duty
                        state      <= ST_STARTUP;
                        drive_duty <= MIN_D;
                        drive_en   <= 1'b1;
                    end
                end
                ST_STARTUP: begin
                    if (duty_low) begin
                        state    <= ST_STOP;
                        drive_en <= 1'b0;
                    end else if (ramp_tick) begin
                        ramp_cnt <= '0;
                        if (step_cnt == STEP_W'(RAMP_STEPS)) begin
                            state      <= ST_RUN;
                            drive_duty <= duty_cycle;
                        end else begin
                            step_cnt <= step_cnt + 1'b1;
                            // Never overshoot a low command, so the ramp stays monotonic
                            if (drive_duty < duty_cycle) begin
                                drive_duty <= drive_duty + 1'b1;
                            end
                        end
                    end else begin
                        ramp_cnt <= ramp_cnt + 1'b1;
                    end
                end
                ST_RUN: begin
                    drive_duty <= duty_cycle;
                    if (duty_low) begin
                        state    <= ST_STOP;
                        drive_en <= 1'b0;
                    end
                end
                ST_POLL_HALL: begin
                    // Wait for the monitor to see a steady valid code again
                    if (!disconnected) begin
                        state <= ST_STOP;
                    end
                end
                ST_ERROR: begin
                    fault <= 1'b1;
                end
                default: state <= ST_STOP;
            endcase
        end
    end

    // Gates may only be enabled while the motor is ramping or running
    a_drive_en_state: assert property (@(posedge clk) disable iff (!rst_n)
        drive_en |-> (state == ST_STARTUP || state == ST_RUN))
        else $error("drive_en high in state %s", state.name());

endmodule

`default_nettype wire

//--- hall_monitor/hall_monitor.sv
/* Hall fault monitor. Samples once every HALL_SAMPLE_DIV cycles; a steady 000 is a
   hardware fault held until rst_n, a steady 111 is a disconnect. */

`timescale 1ns/1ps
`default_nettype none

module hall_monitor import bldc_pkg::*; #(
    parameter int HALL_SAMPLE_DIV   = 64,
    parameter int HALL_STEADY_COUNT = 31
) (
    input  wire logic         clk,
    input  wire logic         rst_n,
    input  wire hall_code_t   hall_s,
    input  wire motor_state_t state,
    output logic              hw_fault,
    output logic              disconnected,
    output logic              fault_event
);

    localparam int DIV_W    = (HALL_SAMPLE_DIV > 1) ? $clog2(HALL_SAMPLE_DIV) : 1;
    localparam int STEADY_W = $clog2(HALL_STEADY_COUNT + 1);
    localparam logic [STEADY_W-1:0] STEADY_LAST = STEADY_W'(HALL_STEADY_COUNT - 1);

    logic [DIV_W-1:0]    div_cnt;
    logic [STEADY_W-1:0] low_cnt, high_cnt, valid_cnt;
    logic sample_tick, hall_valid;

    assign sample_tick = (div_cnt == DIV_W'(HALL_SAMPLE_DIV - 1));
    assign hall_valid  = (hall_s != HALL_ALL_LOW) && (hall_s != HALL_ALL_HIGH);

    // ======================================================================
    // Sample divider
    // ======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= sample_tick ? '0 : div_cnt + 1'b1;
        end
    end

    // ======================================================================
    // Steady-code counters and fault latches
    // ======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            low_cnt      <= '0;
            high_cnt     <= '0;
            valid_cnt    <= '0;
            hw_fault     <= 1'b0;
            disconnected <= 1'b0;
            fault_event  <= 1'b0;
        end else begin
            fault_event <= 1'b0;
            // A latched hardware fault freezes all monitoring until reset
            if (sample_tick && !hw_fault) begin
                // All-low run, counted toward a hardware fault
                if (hall_s != HALL_ALL_LOW) begin
                    low_cnt <= '0;
                end else if (low_cnt == STEADY_LAST) begin
                    low_cnt     <= '0;
                    hw_fault    <= 1'b1;
                    fault_event <= 1'b1;
                end else begin
                    low_cnt <= low_cnt + 1'b1;
                end

                // All-high run, counted toward a disconnect
                if (hall_s != HALL_ALL_HIGH) begin
                    high_cnt <= '0;
                end else if (high_cnt == STEADY_LAST) begin
                    high_cnt <= '0;
                    if (!disconnected) begin
                        disconnected <= 1'b1;
                        fault_event  <= 1'b1;
                    end
                end else begin
                    high_cnt <= high_cnt + 1'b1;
                end

                // Reconnect only counts while the FSM is polling for the sensor
                if (state != ST_POLL_HALL || !hall_valid) begin
                    valid_cnt <= '0;
                end else if (valid_cnt == STEADY_LAST) begin
                    valid_cnt    <= '0;
                    disconnected <= 1'b0;
                end else begin
                    valid_cnt <= valid_cnt + 1'b1;
                end
            end
        end
    end

    // Once latched, the hardware fault must survive until rst_n
    a_hw_fault_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        hw_fault |=> hw_fault)
        else $error("hw_fault cleared without reset");

endmodule

`default_nettype wire

//--- phase_pwm/phase_pwm.sv
/* Single-phase PWM driver with dead time. Carrier runs 0..PWM_MAX; outputs are
   registered. Duty below DEAD_TIME gives no high-side pulse. */

`timescale 1ns/1ps
`default_nettype none

module phase_pwm #(
    parameter int PWM_MAX    = 1023,
    parameter int DUTY_WIDTH = 10,
    parameter int DEAD_TIME  = 3
) (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic [DUTY_WIDTH-1:0] duty,
    input  wire logic                  float_phase,
    output logic                       gate_h,
    output logic                       gate_l
);

    localparam int CNT_W = $clog2(PWM_MAX + 1);
    // One spare bit so duty plus dead time cannot wrap
    localparam int CMP_W = ((CNT_W > DUTY_WIDTH) ? CNT_W : DUTY_WIDTH) + 1;
    localparam logic [CMP_W-1:0] DEAD_X = CMP_W'(DEAD_TIME);

    logic [CNT_W-1:0] cnt;
    logic [CMP_W-1:0] cnt_x, duty_x, low_start;
    logic next_h, next_l;

    // ======================================================================
    // Carrier counter
    // ======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (cnt == CNT_W'(PWM_MAX)) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // ======================================================================
    // Gate decode
    // ======================================================================
    assign cnt_x     = CMP_W'(cnt);
    assign duty_x    = CMP_W'(duty);
    assign low_start = duty_x + DEAD_X;

    // High side on from DEAD_TIME up to duty, low side from duty plus DEAD_TIME to
    // the top, so each edge is separated by a dead-time gap
    assign next_h = !float_phase && (cnt_x >= DEAD_X) && (cnt_x < duty_x);
    assign next_l = !float_phase && (cnt_x >= low_start);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gate_h <= 1'b0;
            gate_l <= 1'b0;
        end else begin
            gate_h <= next_h;
            gate_l <= next_l;
        end
    end

    // Shoot-through guard over the registered outputs
    a_no_shoot_through: assert property (@(posedge clk) disable iff (!rst_n)
        !(gate_h && gate_l))
        else $error("gate_h and gate_l both on");

endmodule

`default_nettype wire

//--- common/bldc_pkg.sv
/* Shared types and the six-step commutation table for the BLDC controller.
   Hall codes 000 and 111 are treated as invalid and float every phase. */

`default_nettype none

package bldc_pkg;

    // Three phases, A in bit 0, B in bit 1, C in bit 2
    localparam int NUM_PHASES = 3;

    // Motor state machine encoding
    typedef enum logic [2:0] {
        ST_STOP      = 3'd0,
        ST_STARTUP   = 3'd1,
        ST_RUN       = 3'd2,
        ST_POLL_HALL = 3'd3,
        ST_ERROR     = 3'd4
    } motor_state_t;

    typedef logic [2:0] hall_code_t;
    typedef logic [2:0] phase_sel_t;
    typedef logic [1:0] phase_idx_t;

    // Pull-ups on the hall lines make 111 the unplugged code
    localparam hall_code_t HALL_ALL_LOW  = 3'b000;
    localparam hall_code_t HALL_ALL_HIGH = 3'b111;

    // Result of one table lookup
    typedef struct packed {
        logic       valid;
        phase_idx_t high;
        phase_idx_t low;
    } commutation_t;

    // Forward table, reversed by swapping high and low
    function automatic commutation_t commutate(hall_code_t hall, logic direction);
        commutation_t c;
        phase_idx_t   tmp;
        c.valid = 1'b1;
        case (hall)
            3'b001: begin c.high = 2'd0; c.low = 2'd1; end
            3'b011: begin c.high = 2'd0; c.low = 2'd2; end
            3'b010: begin c.high = 2'd1; c.low = 2'd2; end
            3'b110: begin c.high = 2'd1; c.low = 2'd0; end
            3'b100: begin c.high = 2'd2; c.low = 2'd0; end
            3'b101: begin c.high = 2'd2; c.low = 2'd1; end
            default: begin
                c.valid = 1'b0;
                c.high  = 2'd0;
                c.low   = 2'd0;
            end
        endcase
        // A direction of 0 runs the motor backwards
        if (!direction) begin
            tmp    = c.high;
            c.high = c.low;
            c.low  = tmp;
        end
        return c;
    endfunction

endpackage

`default_nettype wire
